//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= ooo_core_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- all.f
+incdir+hw
hw/isa_pkg.sv
hw/rs_pkg.sv
hw/issue_selector.sv
hw/dispatch_unit.sv
hw/reservation_station.sv
hw/exec_units.sv
hw/ooo_core_top.sv
tests/ooo_core_checker.sv
tests/ooo_core_assert.sv
tests/ooo_core_tb.sv

//--- hw/dispatch_unit.sv
`default_nettype none
`include "rs_params.svh"

module dispatch_unit
	import isa_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic [`DISPATCH_WIDTH-1:0] disp_valid,
	input opcode_t [`DISPATCH_WIDTH-1:0] disp_opcode,
	input logic [`DISPATCH_WIDTH-1:0][`PREG_BITS-1:0] disp_dest,
	input logic [`DISPATCH_WIDTH-1:0][`PREG_BITS-1:0] disp_src1,
	input logic [`DISPATCH_WIDTH-1:0][`PREG_BITS-1:0] disp_src2,
	input logic reg_wr_en,
	input logic [`PREG_BITS-1:0] reg_wr_tag,
	input logic [`DATA_BITS-1:0] reg_wr_value,
	input logic [`NUM_FU-1:0] cdb_valid,
	input logic [`NUM_FU-1:0][`PREG_BITS-1:0] cdb_tag,
	input logic [`NUM_FU-1:0][`DATA_BITS-1:0] cdb_value,
	output logic [`DISPATCH_WIDTH-1:0] ins_valid,
	output opcode_t [`DISPATCH_WIDTH-1:0] ins_opcode,
	output logic [`DISPATCH_WIDTH-1:0][`PREG_BITS-1:0] ins_dest,
	output logic [`DISPATCH_WIDTH-1:0][`PREG_BITS-1:0] ins_tag1,
	output logic [`DISPATCH_WIDTH-1:0][`PREG_BITS-1:0] ins_tag2,
	output logic [`DISPATCH_WIDTH-1:0] ins_rdy1,
	output logic [`DISPATCH_WIDTH-1:0] ins_rdy2,
	output logic [`DISPATCH_WIDTH-1:0][`DATA_BITS-1:0] ins_val1,
	output logic [`DISPATCH_WIDTH-1:0][`DATA_BITS-1:0] ins_val2
);

	// physical register file, value plus ready bit per tag
	logic [`DATA_BITS-1:0] reg_value [`NUM_PREGS];
	logic [`NUM_PREGS-1:0] reg_ready;

	// {ready, value} for one source of one lane
	// older lanes override, then bus bypass, then the file
	function automatic logic [`DATA_BITS:0] resolve_src(input int lane,
			input logic [`PREG_BITS-1:0] tag);
		logic [`DATA_BITS:0] res;
		res = {reg_ready[tag], reg_value[tag]};
		for (int k = 0; k < `NUM_FU; k++) begin
			if (cdb_valid[k] && cdb_tag[k] == tag)
				res = {1'b1, cdb_value[k]};
		end
		// an older lane in the same group produces this tag
		for (int o = 0; o < lane; o++) begin
			if (disp_valid[o] && disp_dest[o] == tag)
				res[`DATA_BITS] = 1'b0;
		end
		return res;
	endfunction

	////////////////////////////////////////////////////////////
	// operand read toward the station
	////////////////////////////////////////////////////////////

	assign ins_valid  = disp_valid;
	assign ins_opcode = disp_opcode;
	assign ins_dest   = disp_dest;
	assign ins_tag1   = disp_src1;
	assign ins_tag2   = disp_src2;

	always_comb begin
		for (int l = 0; l < `DISPATCH_WIDTH; l++) begin
			{ins_rdy1[l], ins_val1[l]} = resolve_src(l, disp_src1[l]);
			{ins_rdy2[l], ins_val2[l]} = resolve_src(l, disp_src2[l]);
		end
	end

	////////////////////////////////////////////////////////////
	// file update
	////////////////////////////////////////////////////////////

	// later writes win: bus, then preload, then dispatch clear
	always_ff @(posedge clock) begin
		if (reset) begin
			for (int r = 0; r < `NUM_PREGS; r++) begin
				reg_value[r] <= '0;
				reg_ready[r] <= 1'b1;
			end
		end else begin
			for (int k = 0; k < `NUM_FU; k++) begin
				if (cdb_valid[k]) begin
					reg_value[cdb_tag[k]] <= cdb_value[k];
					reg_ready[cdb_tag[k]] <= 1'b1;
				end
			end
			if (reg_wr_en) begin
				reg_value[reg_wr_tag] <= reg_wr_value;
				reg_ready[reg_wr_tag] <= 1'b1;
			end
			// new producer in flight
			for (int l = 0; l < `DISPATCH_WIDTH; l++) begin
				if (disp_valid[l])
					reg_ready[disp_dest[l]] <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

//--- hw/exec_units.sv
`default_nettype none
`include "rs_params.svh"

module exec_units
	import isa_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic [`NUM_FU-1:0] iss_valid,
	input opcode_t [`NUM_FU-1:0] iss_opcode,
	input logic [`NUM_FU-1:0][`PREG_BITS-1:0] iss_dest,
	input logic [`NUM_FU-1:0][`DATA_BITS-1:0] iss_a,
	input logic [`NUM_FU-1:0][`DATA_BITS-1:0] iss_b,
	output logic [`NUM_FU-1:0] cdb_valid,
	output logic [`NUM_FU-1:0][`PREG_BITS-1:0] cdb_tag,
	output logic [`NUM_FU-1:0][`DATA_BITS-1:0] cdb_value
);

	logic [`NUM_FU-1:0][`DATA_BITS-1:0] alu_result;

	////////////////////////////////////////////////////////////
	// unit 0, add and sub
	////////////////////////////////////////////////////////////

	// wraps modulo 2^DATA_BITS
	always_comb begin
		case (iss_opcode[fu_arith])
			op_add:  alu_result[fu_arith] = iss_a[fu_arith] + iss_b[fu_arith];
			op_sub:  alu_result[fu_arith] = iss_a[fu_arith] - iss_b[fu_arith];
			default: alu_result[fu_arith] = '0;
		endcase
	end

	////////////////////////////////////////////////////////////
	// unit 1, bitwise ops
	////////////////////////////////////////////////////////////

	always_comb begin
		case (iss_opcode[fu_logic])
			op_and:  alu_result[fu_logic] = iss_a[fu_logic] & iss_b[fu_logic];
			op_or:   alu_result[fu_logic] = iss_a[fu_logic] | iss_b[fu_logic];
			op_xor:  alu_result[fu_logic] = iss_a[fu_logic] ^ iss_b[fu_logic];
			default: alu_result[fu_logic] = '0;
		endcase
	end

	// one bus lane per unit, result a cycle after issue
	always_ff @(posedge clock) begin
		if (reset)
			cdb_valid <= '0;
		else
			cdb_valid <= iss_valid;
	end

	always_ff @(posedge clock) begin
		cdb_tag   <= iss_dest;
		cdb_value <= alu_result;
	end

endmodule

`default_nettype wire

//--- hw/isa_pkg.sv
`default_nettype none

package isa_pkg;

	// alu opcodes, already decoded upstream
	typedef enum logic [2:0] {
		op_add,
		op_sub,
		op_and,
		op_or,
		op_xor
	} opcode_t;

	// unit class doubles as the unit / bus lane number
	typedef enum logic {
		fu_arith,
		fu_logic
	} fu_class_t;

	// add and sub on unit 0, bitwise ops on unit 1
	function automatic fu_class_t fu_of(input opcode_t op);
		case (op)
			op_add, op_sub: return fu_arith;
			default: return fu_logic;
		endcase
	endfunction

endpackage

`default_nettype wire

//--- hw/issue_selector.sv
`default_nettype none
`include "rs_params.svh"

module issue_selector
	import isa_pkg::*;
	import rs_pkg::*;
(
	input entry_state_t [`RS_SIZE-1:0] entry_state,
	input opcode_t [`RS_SIZE-1:0] entry_opcode,
	output logic [`NUM_FU-1:0] sel_valid,
	output logic [`NUM_FU-1:0][`RS_IDX_BITS-1:0] sel_idx
);

	fu_class_t [`RS_SIZE-1:0] entry_class;
	// ready entries per unit
	logic [`NUM_FU-1:0][`RS_SIZE-1:0] candidate;

	always_comb begin
		for (int i = 0; i < `RS_SIZE; i++)
			entry_class[i] = fu_of(entry_opcode[i]);
	end

	always_comb begin
		for (int u = 0; u < `NUM_FU; u++) begin
			for (int i = 0; i < `RS_SIZE; i++) begin
				candidate[u][i] = (entry_state[i] == st_ready) &&
					(entry_class[i] == fu_class_t'(u));
			end
		end
	end

	////////////////////////////////////////////////////////////
	// lowest index wins, i.e. the oldest
	////////////////////////////////////////////////////////////

	always_comb begin
		for (int u = 0; u < `NUM_FU; u++) begin
			sel_valid[u] = 1'b0;
			sel_idx[u]   = '0;
			// scan downward so the last hit is index 0 side
			for (int i = `RS_SIZE - 1; i >= 0; i--) begin
				if (candidate[u][i]) begin
					sel_valid[u] = 1'b1;
					sel_idx[u]   = `RS_IDX_BITS'(i);
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- hw/ooo_core_top.sv
`default_nettype none
`include "rs_params.svh"

module ooo_core_top
	import isa_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic [`DISPATCH_WIDTH-1:0] disp_valid,
	input opcode_t [`DISPATCH_WIDTH-1:0] disp_opcode,
	input logic [`DISPATCH_WIDTH-1:0][`PREG_BITS-1:0] disp_dest,
	input logic [`DISPATCH_WIDTH-1:0][`PREG_BITS-1:0] disp_src1,
	input logic [`DISPATCH_WIDTH-1:0][`PREG_BITS-1:0] disp_src2,
	input logic reg_wr_en,
	input logic [`PREG_BITS-1:0] reg_wr_tag,
	input logic [`DATA_BITS-1:0] reg_wr_value,
	output logic [`RS_CNT_BITS-1:0] num_free,
	output logic [`NUM_FU-1:0] cdb_valid,
	output logic [`NUM_FU-1:0][`PREG_BITS-1:0] cdb_tag,
	output logic [`NUM_FU-1:0][`DATA_BITS-1:0] cdb_value
);

	// dispatch to station
	logic [`DISPATCH_WIDTH-1:0] ins_valid, ins_rdy1, ins_rdy2;
	opcode_t [`DISPATCH_WIDTH-1:0] ins_opcode;
	logic [`DISPATCH_WIDTH-1:0][`PREG_BITS-1:0] ins_dest, ins_tag1, ins_tag2;
	logic [`DISPATCH_WIDTH-1:0][`DATA_BITS-1:0] ins_val1, ins_val2;

	// station to units
	logic [`NUM_FU-1:0] iss_valid;
	opcode_t [`NUM_FU-1:0] iss_opcode;
	logic [`NUM_FU-1:0][`PREG_BITS-1:0] iss_dest;
	logic [`NUM_FU-1:0][`DATA_BITS-1:0] iss_a, iss_b;

	dispatch_unit dispatch_unit_inst (
		.clock, .reset,
		.disp_valid, .disp_opcode, .disp_dest, .disp_src1, .disp_src2,
		.reg_wr_en, .reg_wr_tag, .reg_wr_value,
		.cdb_valid, .cdb_tag, .cdb_value,
		.ins_valid, .ins_opcode, .ins_dest, .ins_tag1, .ins_tag2,
		.ins_rdy1, .ins_rdy2, .ins_val1, .ins_val2
	);

	reservation_station reservation_station_inst (
		.clock, .reset,
		.ins_valid, .ins_opcode, .ins_dest, .ins_tag1, .ins_tag2,
		.ins_rdy1, .ins_rdy2, .ins_val1, .ins_val2,
		.cdb_valid, .cdb_tag, .cdb_value,
		.iss_valid, .iss_opcode, .iss_dest, .iss_a, .iss_b,
		.num_free
	);

	// bus feeds back to dispatch and station as well as the outputs
	exec_units exec_units_inst (
		.clock, .reset,
		.iss_valid, .iss_opcode, .iss_dest, .iss_a, .iss_b,
		.cdb_valid, .cdb_tag, .cdb_value
	);

endmodule

`default_nettype wire

//--- hw/reservation_station.sv
`default_nettype none
`include "rs_params.svh"

module reservation_station
	import isa_pkg::*;
	import rs_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic [`DISPATCH_WIDTH-1:0] ins_valid,
	input opcode_t [`DISPATCH_WIDTH-1:0] ins_opcode,
	input logic [`DISPATCH_WIDTH-1:0][`PREG_BITS-1:0] ins_dest,
	input logic [`DISPATCH_WIDTH-1:0][`PREG_BITS-1:0] ins_tag1,
	input logic [`DISPATCH_WIDTH-1:0][`PREG_BITS-1:0] ins_tag2,
	input logic [`DISPATCH_WIDTH-1:0] ins_rdy1,
	input logic [`DISPATCH_WIDTH-1:0] ins_rdy2,
	input logic [`DISPATCH_WIDTH-1:0][`DATA_BITS-1:0] ins_val1,
	input logic [`DISPATCH_WIDTH-1:0][`DATA_BITS-1:0] ins_val2,
	input logic [`NUM_FU-1:0] cdb_valid,
	input logic [`NUM_FU-1:0][`PREG_BITS-1:0] cdb_tag,
	input logic [`NUM_FU-1:0][`DATA_BITS-1:0] cdb_value,
	output logic [`NUM_FU-1:0] iss_valid,
	output opcode_t [`NUM_FU-1:0] iss_opcode,
	output logic [`NUM_FU-1:0][`PREG_BITS-1:0] iss_dest,
	output logic [`NUM_FU-1:0][`DATA_BITS-1:0] iss_a,
	output logic [`NUM_FU-1:0][`DATA_BITS-1:0] iss_b,
	output logic [`RS_CNT_BITS-1:0] num_free
);

	// entry table, index 0 is the oldest
	entry_state_t [`RS_SIZE-1:0] state_q, nxt_state;
	opcode_t [`RS_SIZE-1:0] opcode_q, nxt_opcode;
	logic [`RS_SIZE-1:0][`PREG_BITS-1:0] dest_q, nxt_dest;
	logic [`RS_SIZE-1:0][`PREG_BITS-1:0] tag1_q, nxt_tag1;
	logic [`RS_SIZE-1:0][`PREG_BITS-1:0] tag2_q, nxt_tag2;
	logic [`RS_SIZE-1:0] rdy1_q, nxt_rdy1;
	logic [`RS_SIZE-1:0] rdy2_q, nxt_rdy2;
	logic [`RS_SIZE-1:0][`DATA_BITS-1:0] val1_q, nxt_val1;
	logic [`RS_SIZE-1:0][`DATA_BITS-1:0] val2_q, nxt_val2;

	// operands after this cycle's bus capture
	logic [`RS_SIZE-1:0] wake_rdy1, wake_rdy2;
	logic [`RS_SIZE-1:0][`DATA_BITS-1:0] wake_val1, wake_val2;

	logic [`NUM_FU-1:0] sel_valid;
	logic [`NUM_FU-1:0][`RS_IDX_BITS-1:0] sel_idx;
	logic [`RS_SIZE-1:0] issued;
	// next free slot while compacting, ends as the new occupancy
	logic [`RS_CNT_BITS-1:0] wr_ptr;

	issue_selector issue_selector_inst (
		.entry_state  (state_q),
		.entry_opcode (opcode_q),
		.sel_valid    (sel_valid),
		.sel_idx      (sel_idx)
	);

	////////////////////////////////////////////////////////////
	// wakeup, both sources against every bus lane
	////////////////////////////////////////////////////////////

	always_comb begin
		wake_rdy1 = rdy1_q;
		wake_rdy2 = rdy2_q;
		wake_val1 = val1_q;
		wake_val2 = val2_q;
		for (int i = 0; i < `RS_SIZE; i++) begin
			for (int k = 0; k < `NUM_FU; k++) begin
				if (state_q[i] == st_wait && cdb_valid[k]) begin
					if (!rdy1_q[i] && tag1_q[i] == cdb_tag[k]) begin
						wake_rdy1[i] = 1'b1;
						wake_val1[i] = cdb_value[k];
					end
					if (!rdy2_q[i] && tag2_q[i] == cdb_tag[k]) begin
						wake_rdy2[i] = 1'b1;
						wake_val2[i] = cdb_value[k];
					end
				end
			end
		end
	end

	// entries leaving this cycle
	always_comb begin
		issued = '0;
		for (int u = 0; u < `NUM_FU; u++) begin
			if (sel_valid[u])
				issued[sel_idx[u]] = 1'b1;
		end
	end

	////////////////////////////////////////////////////////////
	// compaction, survivors first, then new lanes in order
	////////////////////////////////////////////////////////////

	always_comb begin
		nxt_opcode = opcode_q;
		nxt_dest   = dest_q;
		nxt_tag1   = tag1_q;
		nxt_tag2   = tag2_q;
		nxt_rdy1   = wake_rdy1;
		nxt_rdy2   = wake_rdy2;
		nxt_val1   = wake_val1;
		nxt_val2   = wake_val2;
		for (int i = 0; i < `RS_SIZE; i++)
			nxt_state[i] = st_free;
		wr_ptr = '0;
		for (int i = 0; i < `RS_SIZE; i++) begin
			if (state_q[i] != st_free && !issued[i]) begin
				nxt_state[wr_ptr[`RS_IDX_BITS-1:0]] =
					(wake_rdy1[i] && wake_rdy2[i]) ? st_ready : st_wait;
				nxt_opcode[wr_ptr[`RS_IDX_BITS-1:0]] = opcode_q[i];
				nxt_dest[wr_ptr[`RS_IDX_BITS-1:0]]   = dest_q[i];
				nxt_tag1[wr_ptr[`RS_IDX_BITS-1:0]]   = tag1_q[i];
				nxt_tag2[wr_ptr[`RS_IDX_BITS-1:0]]   = tag2_q[i];
				nxt_rdy1[wr_ptr[`RS_IDX_BITS-1:0]]   = wake_rdy1[i];
				nxt_rdy2[wr_ptr[`RS_IDX_BITS-1:0]]   = wake_rdy2[i];
				nxt_val1[wr_ptr[`RS_IDX_BITS-1:0]]   = wake_val1[i];
				nxt_val2[wr_ptr[`RS_IDX_BITS-1:0]]   = wake_val2[i];
				wr_ptr = wr_ptr + 1'b1;
			end
		end
		// lane 0 lands below lane 1, so index stays age order
		for (int l = 0; l < `DISPATCH_WIDTH; l++) begin
			if (ins_valid[l] && wr_ptr < `RS_CNT_BITS'(`RS_SIZE)) begin
				nxt_state[wr_ptr[`RS_IDX_BITS-1:0]] =
					(ins_rdy1[l] && ins_rdy2[l]) ? st_ready : st_wait;
				nxt_opcode[wr_ptr[`RS_IDX_BITS-1:0]] = ins_opcode[l];
				nxt_dest[wr_ptr[`RS_IDX_BITS-1:0]]   = ins_dest[l];
				nxt_tag1[wr_ptr[`RS_IDX_BITS-1:0]]   = ins_tag1[l];
				nxt_tag2[wr_ptr[`RS_IDX_BITS-1:0]]   = ins_tag2[l];
				nxt_rdy1[wr_ptr[`RS_IDX_BITS-1:0]]   = ins_rdy1[l];
				nxt_rdy2[wr_ptr[`RS_IDX_BITS-1:0]]   = ins_rdy2[l];
				nxt_val1[wr_ptr[`RS_IDX_BITS-1:0]]   = ins_val1[l];
				nxt_val2[wr_ptr[`RS_IDX_BITS-1:0]]   = ins_val2[l];
				wr_ptr = wr_ptr + 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// table and issue registers
	////////////////////////////////////////////////////////////

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `RS_SIZE; i++)
				state_q[i] <= st_free;
			num_free  <= `RS_CNT_BITS'(`RS_SIZE);
			iss_valid <= '0;
		end else begin
			state_q   <= nxt_state;
			num_free  <= `RS_CNT_BITS'(`RS_SIZE) - wr_ptr;
			iss_valid <= sel_valid;
		end
	end

	always_ff @(posedge clock) begin
		opcode_q <= nxt_opcode;
		dest_q   <= nxt_dest;
		tag1_q   <= nxt_tag1;
		tag2_q   <= nxt_tag2;
		rdy1_q   <= nxt_rdy1;
		rdy2_q   <= nxt_rdy2;
		val1_q   <= nxt_val1;
		val2_q   <= nxt_val2;
		// issue payload, qualified by iss_valid
		for (int u = 0; u < `NUM_FU; u++) begin
			iss_opcode[u] <= opcode_q[sel_idx[u]];
			iss_dest[u]   <= dest_q[sel_idx[u]];
			iss_a[u]      <= val1_q[sel_idx[u]];
			iss_b[u]      <= val2_q[sel_idx[u]];
		end
	end

endmodule

`default_nettype wire

//--- hw/rs_params.svh
`ifndef RS_PARAMS_SVH
`define RS_PARAMS_SVH

// station depth and dispatch lanes per cycle
`define RS_SIZE 8
`define DISPATCH_WIDTH 2

// functional units, one bus lane each
`define NUM_FU 2

// physical tags and operand width
`define PREG_BITS 6
`define NUM_PREGS 64
`define DATA_BITS 16

// entry index, and counter wide enough to hold RS_SIZE itself
`define RS_IDX_BITS 3
`define RS_CNT_BITS 4

`endif

//--- hw/rs_pkg.sv
`default_nettype none

package rs_pkg;

	////////////////////////////////////////////////////////////
	// reservation station entry lifecycle
	////////////////////////////////////////////////////////////

	// st_free   slot empty, above the compacted region
	// st_wait   at least one source still pending on the bus
	// st_ready  both operands captured, eligible for issue
	typedef enum logic [1:0] {
		st_free,
		st_wait,
		st_ready
	} entry_state_t;

	// free -> wait or ready on dispatch
	// wait -> ready on bus capture
	// ready -> free on issue

endpackage

`default_nettype wire

//--- tests/ooo_core_assert.sv
`default_nettype none
`include "rs_params.svh"

module ooo_core_assert
	import isa_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic [`DISPATCH_WIDTH-1:0] ins_valid,
	input logic [`RS_CNT_BITS-1:0] num_free,
	input logic [`NUM_FU-1:0] cdb_valid,
	input logic [`NUM_FU-1:0][`PREG_BITS-1:0] cdb_tag
);

	// assertion failures so far
	int assert_errors = 0;

	// occupancy counter stays in range
	free_in_range: assert property (@(posedge clock) disable iff (reset)
		int'(num_free) <= `RS_SIZE)
		else begin
			$error("num_free above station size");
			assert_errors++;
		end

	// environment respects the advertised space
	dispatch_fits: assert property (@(posedge clock) disable iff (reset)
		int'($countones(ins_valid)) <= int'(num_free))
		else begin
			$error("more lanes dispatched than free entries");
			assert_errors++;
		end

	// tags are unique, so two lanes never broadcast the same one
	distinct_bus_tags: assert property (@(posedge clock) disable iff (reset)
		(cdb_valid == 2'b11) |-> (cdb_tag[0] != cdb_tag[1]))
		else begin
			$error("both bus lanes carry the same tag");
			assert_errors++;
		end

endmodule

bind reservation_station ooo_core_assert ooo_core_assert_inst (
	.clock     (clock),
	.reset     (reset),
	.ins_valid (ins_valid),
	.num_free  (num_free),
	.cdb_valid (cdb_valid),
	.cdb_tag   (cdb_tag)
);

`default_nettype wire

//--- tests/ooo_core_checker.sv
`default_nettype none
`include "rs_params.svh"

module ooo_core_checker
	import isa_pkg::*;
(
	input logic clock,
	input logic reset,
	input logic [`DISPATCH_WIDTH-1:0] disp_valid,
	input opcode_t [`DISPATCH_WIDTH-1:0] disp_opcode,
	input logic [`DISPATCH_WIDTH-1:0][`PREG_BITS-1:0] disp_dest,
	input logic [`DISPATCH_WIDTH-1:0][`PREG_BITS-1:0] disp_src1,
	input logic [`DISPATCH_WIDTH-1:0][`PREG_BITS-1:0] disp_src2,
	input logic reg_wr_en,
	input logic [`PREG_BITS-1:0] reg_wr_tag,
	input logic [`DATA_BITS-1:0] reg_wr_value,
	input logic [`RS_CNT_BITS-1:0] num_free,
	input logic [`NUM_FU-1:0] cdb_valid,
	input logic [`NUM_FU-1:0][`PREG_BITS-1:0] cdb_tag,
	input logic [`NUM_FU-1:0][`DATA_BITS-1:0] cdb_value,
	input logic [127:0] test_name,
	input logic end_of_test,
	output logic [`NUM_PREGS-1:0] pending_mask,
	output int err_count
);

	// in-order model of every register
	logic [`DATA_BITS-1:0] model [`NUM_PREGS];
	logic [`DATA_BITS-1:0] expect_val [`NUM_PREGS];
	opcode_t tag_op [`NUM_PREGS];
	logic [127:0] tag_name [`NUM_PREGS];
	int tag_seq [`NUM_PREGS];
	logic [`NUM_PREGS-1:0] ready_at_disp, ever_disp;
	int seq;
	logic after_reset, saw_full;

	function automatic logic [`DATA_BITS-1:0] expected_result(input opcode_t op,
			input logic [`DATA_BITS-1:0] a, input logic [`DATA_BITS-1:0] b);
		case (op)
			op_add: return a + b;
			op_sub: return a - b;
			op_and: return a & b;
			op_or: return a | b;
			default: return a ^ b;
		endcase
	endfunction

	always @(posedge clock) begin
		logic [`PREG_BITS-1:0] t;
		logic [`PREG_BITS-1:0] d;
		if (reset) begin
			for (int r = 0; r < `NUM_PREGS; r++)
				model[r] = '0;
			pending_mask = '0;
			ready_at_disp = '0;
			ever_disp = '0;
			err_count = 0;
			seq = 0;
			after_reset = 1'b1;
			saw_full = 1'b0;
		end else begin
			// first edge out of reset, station must be empty
			if (after_reset && int'(num_free) != `RS_SIZE) begin
				$display("ERR reset: expected %0d, actual %0d", `RS_SIZE, num_free);
				err_count++;
			end
			after_reset = 1'b0;
			if (num_free == '0)
				saw_full = 1'b1;

			////////////////////////////////////////////////////////////
			// bus broadcasts
			////////////////////////////////////////////////////////////
			for (int k = 0; k < `NUM_FU; k++) begin
				if (cdb_valid[k]) begin
					t = cdb_tag[k];
					if (!pending_mask[t]) begin
						if (ever_disp[t])
							$display("duplicate broadcast of tag %0d on lane %0d", t, k);
						else
							$display("broadcast of unknown tag %0d on lane %0d", t, k);
						err_count++;
					end else begin
						if (cdb_value[k] !== expect_val[t]) begin
							$display("ERR %0s: expected %h, actual %h (tag %0d)",
								tag_name[t], expect_val[t], cdb_value[k], t);
							err_count++;
						end
						if (int'(fu_of(tag_op[t])) != k) begin
							$display("ERR %0s: expected lane %0d, actual lane %0d",
								tag_name[t], int'(fu_of(tag_op[t])), k);
							err_count++;
						end
						// older ready entry of the same unit must go first
						for (int u = 0; u < `NUM_PREGS; u++) begin
							if (ready_at_disp[t] && pending_mask[u] && u != int'(t) &&
									ready_at_disp[u] && int'(fu_of(tag_op[u])) == k &&
									tag_seq[u] < tag_seq[t]) begin
								$display("tag %0d broadcast before older ready tag %0d",
									t, u);
								err_count++;
							end
						end
						pending_mask[t] = 1'b0;
					end
				end
			end

			// preload write
			if (reg_wr_en)
				model[reg_wr_tag] = reg_wr_value;

			// dispatch in lane order, lane 0 oldest
			for (int l = 0; l < `DISPATCH_WIDTH; l++) begin
				if (disp_valid[l]) begin
					d = disp_dest[l];
					ready_at_disp[d] = !pending_mask[disp_src1[l]] &&
						!pending_mask[disp_src2[l]];
					expect_val[d] = expected_result(disp_opcode[l],
						model[disp_src1[l]], model[disp_src2[l]]);
					model[d] = expect_val[d];
					tag_op[d] = disp_opcode[l];
					tag_name[d] = test_name;
					tag_seq[d] = seq;
					seq++;
					pending_mask[d] = 1'b1;
					ever_disp[d] = 1'b1;
				end
			end

			if (end_of_test) begin
				for (int r = 0; r < `NUM_PREGS; r++) begin
					if (pending_mask[r]) begin
						$display("missing broadcast for tag %0d of %0s", r, tag_name[r]);
						err_count++;
					end
				end
				if (!saw_full) begin
					$display("station never reported zero free entries");
					err_count++;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- tests/ooo_core_tb.sv
`default_nettype none
`include "rs_params.svh"

module ooo_core_tb
	import isa_pkg::*;
;

	typedef struct packed {
		logic [127:0] name;
		logic [1:0] lanes;
		opcode_t op0;
		logic [`PREG_BITS-1:0] d0, a0, b0;
		opcode_t op1;
		logic [`PREG_BITS-1:0] d1, a1, b1;
	} row_t;

	localparam int WAIT_LIMIT = 2000;

	logic clock;
	logic reset;
	logic [`DISPATCH_WIDTH-1:0] disp_valid;
	opcode_t [`DISPATCH_WIDTH-1:0] disp_opcode;
	logic [`DISPATCH_WIDTH-1:0][`PREG_BITS-1:0] disp_dest, disp_src1, disp_src2;
	logic reg_wr_en;
	logic [`PREG_BITS-1:0] reg_wr_tag;
	logic [`DATA_BITS-1:0] reg_wr_value;
	logic [`RS_CNT_BITS-1:0] num_free;
	logic [`NUM_FU-1:0] cdb_valid;
	logic [`NUM_FU-1:0][`PREG_BITS-1:0] cdb_tag;
	logic [`NUM_FU-1:0][`DATA_BITS-1:0] cdb_value;
	logic [127:0] test_name;
	logic end_of_test;
	logic [`NUM_PREGS-1:0] pending_mask;
	int err_count;
	int timeouts;
	row_t rows [$];
	logic [`PREG_BITS-1:0] rand_dest;

	ooo_core_top ooo_core_top_inst (.*);

	ooo_core_checker checker_inst (.*);

	always #20 clock = ~clock;

	function automatic row_t make_row(input logic [127:0] name, input int lanes,
			input opcode_t op0, input int d0, input int a0, input int b0,
			input opcode_t op1, input int d1, input int a1, input int b1);
		row_t r;
		r.name = name;
		r.lanes = 2'(lanes);
		r.op0 = op0;
		r.d0 = 6'(d0);
		r.a0 = 6'(a0);
		r.b0 = 6'(b0);
		r.op1 = op1;
		r.d1 = 6'(d1);
		r.a1 = 6'(a1);
		r.b1 = 6'(b1);
		return r;
	endfunction

	// no room yet, or a destination still in flight
	function automatic logic row_blocked(input row_t r);
		return int'(num_free) < int'(r.lanes) || pending_mask[r.d0] ||
			(r.lanes == 2'd2 && pending_mask[r.d1]);
	endfunction

	// random destinations rotate through tags 34..63
	function automatic logic [`PREG_BITS-1:0] next_dest();
		rand_dest = (rand_dest == 6'd63) ? 6'd34 : rand_dest + 6'd1;
		return rand_dest;
	endfunction

	task automatic apply_row(input row_t r);
		int waited;
		waited = 0;
		while (row_blocked(r) && waited < WAIT_LIMIT) begin
			@(posedge clock);
			#2;
			waited++;
		end
		if (row_blocked(r)) begin
			$display("timeout waiting for free entries or tags in %0s", r.name);
			timeouts++;
		end else begin
			test_name = r.name;
			disp_valid = (r.lanes == 2'd2) ? 2'b11 : 2'b01;
			disp_opcode[0] = r.op0;
			disp_dest[0] = r.d0;
			disp_src1[0] = r.a0;
			disp_src2[0] = r.b0;
			disp_opcode[1] = r.op1;
			disp_dest[1] = r.d1;
			disp_src1[1] = r.a1;
			disp_src2[1] = r.b1;
			@(posedge clock);
			#2;
			disp_valid = '0;
		end
	endtask

	initial begin
		row_t r;
		int waited;
		int assert_errors;
		void'($urandom(91));
		clock = 1'b0;
		reset = 1'b1;
		disp_valid = '0;
		disp_opcode[0] = op_add;
		disp_opcode[1] = op_add;
		disp_dest = '0;
		disp_src1 = '0;
		disp_src2 = '0;
		reg_wr_en = 1'b0;
		reg_wr_tag = '0;
		reg_wr_value = '0;
		test_name = "reset";
		end_of_test = 1'b0;
		timeouts = 0;
		rand_dest = 6'd33;
		repeat (4) @(posedge clock);
		#2;
		reset = 1'b0;

		// operand preload, tags 1..7
		test_name = "preload";
		for (int t = 1; t < 8; t++) begin
			reg_wr_en = 1'b1;
			reg_wr_tag = 6'(t);
			reg_wr_value = 16'($urandom);
			@(posedge clock);
			#2;
		end
		reg_wr_en = 1'b0;

		////////////////////////////////////////////////////////////
		// stimulus table
		////////////////////////////////////////////////////////////
		rows.push_back(make_row("single_add", 1, op_add, 10, 1, 2, op_add, 0, 0, 0));
		rows.push_back(make_row("single_sub", 1, op_sub, 11, 3, 4, op_add, 0, 0, 0));
		rows.push_back(make_row("single_and", 1, op_and, 12, 5, 6, op_add, 0, 0, 0));
		rows.push_back(make_row("single_or", 1, op_or, 13, 7, 1, op_add, 0, 0, 0));
		rows.push_back(make_row("single_xor", 1, op_xor, 14, 2, 3, op_add, 0, 0, 0));
		// lane 1 reads lane 0 in the same cycle
		rows.push_back(make_row("chain_pair", 2, op_add, 15, 1, 2, op_sub, 16, 15, 3));
		rows.push_back(make_row("chain_xor", 1, op_xor, 17, 16, 15, op_add, 0, 0, 0));
		rows.push_back(make_row("chain_and", 1, op_and, 18, 17, 1, op_add, 0, 0, 0));
		// serial chain, issue falls behind dual dispatch
		for (int i = 0; i < 6; i++)
			rows.push_back(make_row("burst", 2, op_add, 20 + 2 * i, 19 + 2 * i, 2,
				op_sub, 21 + 2 * i, 20 + 2 * i, 3));
		rows.push_back(make_row("same_class", 2, op_or, 32, 1, 2, op_and, 33, 3, 4));
		for (int i = 0; i < 40; i++) begin
			r = make_row("random", 1 + int'($urandom % 2), opcode_t'($urandom % 5),
				0, int'($urandom % 64), int'($urandom % 64),
				opcode_t'($urandom % 5), 0, int'($urandom % 64), int'($urandom % 64));
			r.d0 = next_dest();
			r.d1 = next_dest();
			if ($urandom % 2 == 0)
				r.a1 = r.d0;
			rows.push_back(r);
		end

		foreach (rows[i])
			apply_row(rows[i]);

		// drain, then let the checker list what never came back
		waited = 0;
		while (pending_mask != '0 && waited < WAIT_LIMIT) begin
			@(posedge clock);
			#2;
			waited++;
		end
		if (pending_mask != '0) begin
			$display("timeout waiting for outstanding broadcasts");
			timeouts++;
		end
		end_of_test = 1'b1;
		@(posedge clock);
		#2;
		end_of_test = 1'b0;
		@(posedge clock);
		#2;

		assert_errors =
			ooo_core_top_inst.reservation_station_inst.ooo_core_assert_inst.assert_errors;
		$display("errors: %0d checker, %0d assertions, %0d timeouts",
			err_count, assert_errors, timeouts);
		if (err_count == 0 && assert_errors == 0 && timeouts == 0)
			$display("Simulation finished: PASS");
		else
			$display("Simulation finished: FAIL");
		$finish;
	end

endmodule

`default_nettype wire
